// ==== include/bp_config.svh ====
// size and width constants for the perceptron branch predictor
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// ======================================================================
// history and weights
// ======================================================================

// number of global history bits, also the number of weights per row
`define BP_HIST_LEN 22

// width of one signed weight, saturating at +127 / -128
`define BP_WEIGHT_W 8

// signed dot product width, 22 * 128 fits with room to spare
`define BP_SUM_W 13

// ======================================================================
// storage sizes
// ======================================================================

// weight table rows, index is 8 bits wide
`define BP_TABLE_DEPTH 256

// fetch and resolve address width
`define BP_ADDR_W 32

// resolved branch records waiting for the trainer
`define BP_QUEUE_DEPTH 32

`endif

// ==== src/bp_pkg.sv ====
// shared types, trainer states, weight step opcodes and the index hash
`default_nettype none
`include "bp_config.svh"

package bp_pkg;

	// row index width follows the table depth
	localparam int INDEX_W = $clog2(`BP_TABLE_DEPTH);

	typedef logic [INDEX_W-1:0] bp_index_t;
	typedef logic [`BP_ADDR_W-1:0] bp_addr_t;
	typedef logic [`BP_HIST_LEN-1:0] bp_hist_t;
	typedef logic signed [`BP_WEIGHT_W-1:0] bp_weight_t;
	typedef logic signed [`BP_SUM_W-1:0] bp_sum_t;

	// one packed row of signed weights, element i pairs with history bit i
	typedef bp_weight_t [`BP_HIST_LEN-1:0] bp_row_t;

	// trainer sequence
	typedef enum logic [1:0] {
		ST_CLEAR,
		ST_IDLE,
		ST_READ,
		ST_WRITE
	} train_state_e;

	// per weight update, hold when the weight is already at its limit
	typedef enum logic [1:0] {
		STEP_HOLD,
		STEP_INC,
		STEP_DEC
	} weight_step_e;

	// fold the address into a row index by xor of its bytes
	function automatic bp_index_t bp_hash(input bp_addr_t addr);
		bp_index_t h;
		h = '0;
		for (int b = 0; b < `BP_ADDR_W / INDEX_W; b++)
			h ^= addr[b*INDEX_W +: INDEX_W];
		return h;
	endfunction

endpackage

`default_nettype wire

// ==== src/resolve_queue.sv ====
// resolve_queue module holding resolved branch records in a circular buffer
`timescale 1ns/1ns
`default_nettype none
`include "bp_config.svh"

module resolve_queue (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              push_i,
	input  wire bp_pkg::bp_addr_t  push_pc_i,
	input  wire logic              push_taken_i,
	input  wire logic              pop_i,
	output logic                   entry_valid_o,
	output bp_pkg::bp_addr_t       entry_pc_o,
	output logic                   entry_taken_o,
	output logic                   full_o
);
	import bp_pkg::*;

	localparam int DEPTH = `BP_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	// record storage, pc and outcome kept side by side
	bp_addr_t pc_mem [DEPTH];
	logic taken_mem [DEPTH];

	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	// one extra bit so a full queue is distinct from an empty one
	logic [PTR_W:0] count;
	logic do_push;
	logic do_pop;

	// ======================================================================
	// status and head entry
	// ======================================================================

	assign full_o = (count == (PTR_W+1)'(DEPTH));
	assign entry_valid_o = (count != '0);

	// head record is shown as soon as it is in the buffer
	assign entry_pc_o = pc_mem[head];
	assign entry_taken_o = taken_mem[head];

	// a push while full is simply lost, even if a pop happens too
	assign do_push = push_i && !full_o;
	assign do_pop = pop_i && entry_valid_o;

	// ======================================================================
	// pointers and occupancy
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (do_push)
				tail <= tail + 1'b1;
			if (do_pop)
				head <= head + 1'b1;
			count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
		end
	end

	// payload write at the tail slot
	always_ff @(posedge clk) begin
		if (do_push) begin
			pc_mem[tail] <= push_pc_i;
			taken_mem[tail] <= push_taken_i;
		end
	end

	// trainer must only pop what it has been shown
	assert property (@(posedge clk) disable iff (rst) pop_i |-> entry_valid_o)
		else $error("resolve_queue: pop with empty queue");

endmodule

`default_nettype wire

// ==== src/weight_table.sv ====
// weight_table module with one write port and two registered read ports
`timescale 1ns/1ns
`default_nettype none
`include "bp_config.svh"

module weight_table (
	input  wire logic               clk,
	// write port, driven by the trainer
	input  wire logic               wr_en_i,
	input  wire bp_pkg::bp_index_t  wr_idx_i,
	input  wire bp_pkg::bp_row_t    wr_row_i,
	// predict read port
	input  wire bp_pkg::bp_index_t  pred_idx_i,
	output bp_pkg::bp_row_t         pred_row_o,
	// train read port
	input  wire bp_pkg::bp_index_t  train_idx_i,
	output bp_pkg::bp_row_t         train_row_o
);
	import bp_pkg::*;

	localparam int DEPTH = `BP_TABLE_DEPTH;

	// weight rows, cleared by the trainer after reset
	bp_row_t mem [DEPTH];

	// ======================================================================
	// write port
	// ======================================================================

	always_ff @(posedge clk) begin
		if (wr_en_i)
			mem[wr_idx_i] <= wr_row_i;
	end

	// ======================================================================
	// read ports
	// ======================================================================

	// data is registered, so a row is valid one cycle after its index
	// a read that meets a write to the same row sees the old contents
	always_ff @(posedge clk) begin
		pred_row_o <= mem[pred_idx_i];
	end

	// separate port so training never stalls lookups
	always_ff @(posedge clk) begin
		train_row_o <= mem[train_idx_i];
	end

endmodule

`default_nettype wire

// ==== src/perceptron_trainer.sv ====
// perceptron_trainer module with row clear, saturating update and global history
`timescale 1ns/1ns
`default_nettype none
`include "bp_config.svh"

module perceptron_trainer (
	input  wire logic               clk,
	input  wire logic               rst,
	// head of the resolve queue
	input  wire logic               entry_valid_i,
	input  wire bp_pkg::bp_addr_t   entry_pc_i,
	input  wire logic               entry_taken_i,
	output logic                    pop_o,
	// train read port of the table
	output bp_pkg::bp_index_t       rd_idx_o,
	input  wire bp_pkg::bp_row_t    rd_row_i,
	// table write port
	output logic                    wr_en_o,
	output bp_pkg::bp_index_t       wr_idx_o,
	output bp_pkg::bp_row_t         wr_row_o,
	output bp_pkg::bp_hist_t        history_o,
	output logic                    busy_o
);
	import bp_pkg::*;

	localparam bp_weight_t W_MAX = {1'b0, {(`BP_WEIGHT_W-1){1'b1}}};
	localparam bp_weight_t W_MIN = {1'b1, {(`BP_WEIGHT_W-1){1'b0}}};
	localparam bp_index_t LAST_ROW = bp_index_t'(`BP_TABLE_DEPTH - 1);

	train_state_e state;
	train_state_e state_nxt;
	bp_index_t clr_idx;
	bp_hist_t history_q;
	// branch being trained
	bp_index_t cur_idx;
	logic cur_taken;
	weight_step_e step [`BP_HIST_LEN];
	bp_row_t new_row;

	// ======================================================================
	// state machine
	// ======================================================================

	// accept only when idle, one entry per three cycles
	assign pop_o = (state == ST_IDLE) && entry_valid_i;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_CLEAR: if (clr_idx == LAST_ROW) state_nxt = ST_IDLE;
			ST_IDLE:  if (entry_valid_i) state_nxt = ST_READ;
			ST_READ:  state_nxt = ST_WRITE;
			ST_WRITE: state_nxt = ST_IDLE;
			default:  state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_CLEAR;
			clr_idx <= '0;
			history_q <= '0;
		end else begin
			state <= state_nxt;
			if (state == ST_CLEAR)
				clr_idx <= clr_idx + 1'b1;
			// outcome enters at bit 0 on the same edge as the row write
			if (state == ST_WRITE)
				history_q <= {history_q[`BP_HIST_LEN-2:0], cur_taken};
		end
	end

	// latch the popped record
	always_ff @(posedge clk) begin
		if (pop_o) begin
			cur_idx <= bp_hash(entry_pc_i);
			cur_taken <= entry_taken_i;
		end
	end

	// ======================================================================
	// weight update
	// ======================================================================

	// pre-shift history decides the direction of every weight
	always_comb begin
		bp_weight_t w;
		for (int i = 0; i < `BP_HIST_LEN; i++) begin
			w = rd_row_i[i];
			if (cur_taken == history_q[i])
				step[i] = (w == W_MAX) ? STEP_HOLD : STEP_INC;
			else
				step[i] = (w == W_MIN) ? STEP_HOLD : STEP_DEC;
			case (step[i])
				STEP_INC: new_row[i] = w + bp_weight_t'(1);
				STEP_DEC: new_row[i] = w - bp_weight_t'(1);
				default:  new_row[i] = w;
			endcase
		end
	end

	// row read in ST_READ, written back in ST_WRITE
	assign rd_idx_o = cur_idx;
	assign wr_en_o = (state == ST_CLEAR) || (state == ST_WRITE);
	assign wr_idx_o = (state == ST_CLEAR) ? clr_idx : cur_idx;
	assign wr_row_o = (state == ST_CLEAR) ? '0 : new_row;

	assign history_o = history_q;
	// busy through the clear and while any work is pending
	assign busy_o = (state != ST_IDLE) || entry_valid_i;

	// the row of a popped record is written back in the write step two cycles later
	assert property (@(posedge clk) disable iff (rst)
		pop_o |-> ##2 (wr_en_o && state == ST_WRITE &&
			wr_idx_o == bp_hash($past(entry_pc_i, 2))))
		else $error("perceptron_trainer: popped row not written back in the write step");

	// each trained weight moves at most one step from the table copy
	for (genvar g = 0; g < `BP_HIST_LEN; g++) begin : g_step_chk
		assert property (@(posedge clk) disable iff (rst)
			state == ST_WRITE |->
				(int'($signed(wr_row_o[g])) - int'($signed(rd_row_i[g]))) inside {-1, 0, 1})
			else $error("perceptron_trainer: weight %0d moved by more than one", g);
	end

endmodule

`default_nettype wire

// ==== src/perceptron_predictor.sv ====
// perceptron_predictor module with index hash, dot product and registered guess
`timescale 1ns/1ns
`default_nettype none
`include "bp_config.svh"

module perceptron_predictor #(
	parameter int ID_W = 8
) (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               lookup_valid_i,
	input  wire bp_pkg::bp_addr_t   lookup_addr_i,
	input  wire logic [ID_W-1:0]    lookup_id_i,
	input  wire bp_pkg::bp_hist_t   history_i,
	// predict read port of the table
	output bp_pkg::bp_index_t       rd_idx_o,
	input  wire bp_pkg::bp_row_t    rd_row_i,
	output logic                    pred_valid_o,
	output logic                    pred_taken_o,
	output logic [ID_W-1:0]         pred_id_o
);
	import bp_pkg::*;

	// stage 1 follows the row read through the table
	logic s1_valid;
	logic [ID_W-1:0] s1_id;
	bp_hist_t s1_hist;
	bp_sum_t dot_sum;

	// ======================================================================
	// stage 0, index
	// ======================================================================

	// table registers the row, so the index goes out unregistered
	assign rd_idx_o = bp_hash(lookup_addr_i);

	always_ff @(posedge clk) begin
		if (rst)
			s1_valid <= 1'b0;
		else
			s1_valid <= lookup_valid_i;
	end

	// history as it stood when the lookup arrived
	always_ff @(posedge clk) begin
		if (lookup_valid_i) begin
			s1_id <= lookup_id_i;
			s1_hist <= history_i;
		end
	end

	// ======================================================================
	// stage 1, dot product
	// ======================================================================

	// add the weight when its history bit is 1, subtract when it is 0
	always_comb begin
		bp_weight_t w;
		bp_sum_t term;
		dot_sum = '0;
		for (int i = 0; i < `BP_HIST_LEN; i++) begin
			w = rd_row_i[i];
			term = {{(`BP_SUM_W-`BP_WEIGHT_W){w[`BP_WEIGHT_W-1]}}, w};
			if (s1_hist[i])
				dot_sum = dot_sum + term;
			else
				dot_sum = dot_sum - term;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			pred_valid_o <= 1'b0;
		else
			pred_valid_o <= s1_valid;
	end

	// zero or positive sum means taken
	always_ff @(posedge clk) begin
		pred_taken_o <= !dot_sum[`BP_SUM_W-1];
		pred_id_o <= s1_id;
	end

endmodule

`default_nettype wire

// ==== src/branch_predictor_top.sv ====
// branch_predictor_top module connecting queue, trainer, weight table and predictor
`timescale 1ns/1ns
`default_nettype none

module branch_predictor_top #(
	parameter int ID_W = 8
) (
	input  wire logic               clk,
	input  wire logic               rst,
	// lookup side
	input  wire logic               lookup_valid_i,
	input  wire bp_pkg::bp_addr_t   lookup_addr_i,
	input  wire logic [ID_W-1:0]    lookup_id_i,
	// resolved branches
	input  wire logic               resolve_valid_i,
	input  wire bp_pkg::bp_addr_t   resolve_pc_i,
	input  wire logic               resolve_taken_i,
	output logic                    pred_valid_o,
	output logic                    pred_taken_o,
	output logic [ID_W-1:0]         pred_id_o,
	output logic                    queue_full_o,
	output logic                    train_busy_o
);
	import bp_pkg::*;

	// queue to trainer
	logic entry_valid;
	bp_addr_t entry_pc;
	logic entry_taken;
	logic pop;
	// trainer and table
	bp_index_t train_rd_idx;
	bp_row_t train_row;
	logic wr_en;
	bp_index_t wr_idx;
	bp_row_t wr_row;
	bp_hist_t global_history;
	// predictor and table
	bp_index_t pred_rd_idx;
	bp_row_t pred_row;

	// ======================================================================
	// input side
	// ======================================================================

	resolve_queue u_queue (
		.clk           (clk),
		.rst           (rst),
		.push_i        (resolve_valid_i),
		.push_pc_i     (resolve_pc_i),
		.push_taken_i  (resolve_taken_i),
		.pop_i         (pop),
		.entry_valid_o (entry_valid),
		.entry_pc_o    (entry_pc),
		.entry_taken_o (entry_taken),
		.full_o        (queue_full_o)
	);

	// ======================================================================
	// training and storage
	// ======================================================================

	perceptron_trainer u_trainer (
		.clk           (clk),
		.rst           (rst),
		.entry_valid_i (entry_valid),
		.entry_pc_i    (entry_pc),
		.entry_taken_i (entry_taken),
		.pop_o         (pop),
		.rd_idx_o      (train_rd_idx),
		.rd_row_i      (train_row),
		.wr_en_o       (wr_en),
		.wr_idx_o      (wr_idx),
		.wr_row_o      (wr_row),
		.history_o     (global_history),
		.busy_o        (train_busy_o)
	);

	weight_table u_table (
		.clk         (clk),
		.wr_en_i     (wr_en),
		.wr_idx_i    (wr_idx),
		.wr_row_i    (wr_row),
		.pred_idx_i  (pred_rd_idx),
		.pred_row_o  (pred_row),
		.train_idx_i (train_rd_idx),
		.train_row_o (train_row)
	);

	// ======================================================================
	// output side
	// ======================================================================

	perceptron_predictor #(
		.ID_W (ID_W)
	) u_predictor (
		.clk            (clk),
		.rst            (rst),
		.lookup_valid_i (lookup_valid_i),
		.lookup_addr_i  (lookup_addr_i),
		.lookup_id_i    (lookup_id_i),
		.history_i      (global_history),
		.rd_idx_o       (pred_rd_idx),
		.rd_row_i       (pred_row),
		.pred_valid_o   (pred_valid_o),
		.pred_taken_o   (pred_taken_o),
		.pred_id_o      (pred_id_o)
	);

endmodule

`default_nettype wire

// ==== sim/tb_branch_predictor.sv ====
// tb_branch_predictor testbench with clock, reset, xorshift stimulus, perceptron model, watchdog
`timescale 1ns/1ns
`default_nettype none
`include "bp_config.svh"

module tb_branch_predictor;

	localparam int HL = `BP_HIST_LEN;
	localparam int ROWS = `BP_TABLE_DEPTH;
	localparam int AW = `BP_ADDR_W;
	localparam int QDEPTH = `BP_QUEUE_DEPTH;
	localparam int ID_W = 8;
	localparam int W_MAX = (1 << (`BP_WEIGHT_W - 1)) - 1;
	localparam int W_MIN = -(1 << (`BP_WEIGHT_W - 1));

	// trainer phases as seen from the outside
	localparam int PH_CLEAR = 0;
	localparam int PH_IDLE = 1;
	localparam int PH_READ = 2;
	localparam int PH_WRITE = 3;

	// ======================================================================
	// test lengths and run limit
	// ======================================================================

	localparam int P2_LOOKUPS = 64;
	localparam int P3_ROUNDS = 8;
	localparam int P3_BURST = 20;
	localparam int P3_LOOKUPS = 16;
	localparam int GROUP_LEN = 20;
	localparam int SAT_GROUPS = 15;
	localparam int ALT_GROUPS = 30;
	// enough back to back pushes to outrun one pop every three cycles
	localparam int OVF_BURST = 64;
	localparam int OVF_LOOKUPS = 32;
	localparam int N_RESOLVES = P3_ROUNDS * P3_BURST + (SAT_GROUPS + ALT_GROUPS) * GROUP_LEN
		+ OVF_BURST;
	localparam int N_LOOKUPS = 1 + P2_LOOKUPS + P3_ROUNDS * P3_LOOKUPS + 3 + OVF_LOOKUPS;
	localparam int WATCHDOG_CYCLES = N_RESOLVES * 3 + N_LOOKUPS * 4 + 2000;

	logic clk;
	logic rst;
	logic lookup_valid_i;
	logic [AW-1:0] lookup_addr_i;
	logic [ID_W-1:0] lookup_id_i;
	logic resolve_valid_i;
	logic [AW-1:0] resolve_pc_i;
	logic resolve_taken_i;
	logic pred_valid_o;
	logic pred_taken_o;
	logic [ID_W-1:0] pred_id_o;
	logic queue_full_o;
	logic train_busy_o;

	// reference model, weights kept as plain integers
	int model_w [ROWS][HL];
	logic [HL-1:0] model_hist;
	logic [31:0] rng_state;
	// expected outputs in flight, slot 1 is due in the current cycle
	logic exp_valid [2];
	logic exp_taken [2];
	logic [ID_W-1:0] exp_id [2];
	logic [AW-1:0] pc_pool [4];
	// queue occupancy and trainer phase for the current cycle
	int q_count;
	int tr_phase;
	int clr_n;
	// push of the previous cycle that found room in the queue
	logic push_acc;
	int accepted;
	int dropped;

	branch_predictor_top u_dut (
		.clk             (clk),
		.rst             (rst),
		.lookup_valid_i  (lookup_valid_i),
		.lookup_addr_i   (lookup_addr_i),
		.lookup_id_i     (lookup_id_i),
		.resolve_valid_i (resolve_valid_i),
		.resolve_pc_i    (resolve_pc_i),
		.resolve_taken_i (resolve_taken_i),
		.pred_valid_o    (pred_valid_o),
		.pred_taken_o    (pred_taken_o),
		.pred_id_o       (pred_id_o),
		.queue_full_o    (queue_full_o),
		.train_busy_o    (train_busy_o)
	);

	// 8 ns clock
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ======================================================================
	// helpers
	// ======================================================================

	function automatic logic [31:0] next_rand();
		logic [31:0] s;
		s = rng_state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		rng_state = s;
		return s;
	endfunction

	// row index is the xor of the four address bytes
	function automatic int fold_index(input logic [AW-1:0] a);
		return int'(a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24]);
	endfunction

	// sign of the dot product, weight added for a 1 in history, subtracted for a 0
	function automatic logic model_predict(input logic [AW-1:0] a);
		int idx;
		int sum;
		idx = fold_index(a);
		sum = 0;
		for (int i = 0; i < HL; i++) begin
			if (model_hist[i])
				sum = sum + model_w[idx][i];
			else
				sum = sum - model_w[idx][i];
		end
		return (sum >= 0);
	endfunction

	// one step toward agreement, clamped at the weight limits
	task automatic model_train(input logic [AW-1:0] pc, input logic taken);
		int idx;
		idx = fold_index(pc);
		for (int i = 0; i < HL; i++) begin
			if (taken == model_hist[i]) begin
				if (model_w[idx][i] < W_MAX)
					model_w[idx][i] = model_w[idx][i] + 1;
			end else if (model_w[idx][i] > W_MIN) begin
				model_w[idx][i] = model_w[idx][i] - 1;
			end
		end
		model_hist = {model_hist[HL-2:0], taken};
	endtask

	// step the queue and trainer phase across one clock edge
	// 256 clear cycles, then one pop when idle and three cycles per entry
	task automatic advance_queue_model();
		logic pop;
		pop = (tr_phase == PH_IDLE) && (q_count != 0);
		q_count = q_count + int'(push_acc) - int'(pop);
		case (tr_phase)
			PH_CLEAR: begin
				if (clr_n == ROWS - 1)
					tr_phase = PH_IDLE;
				clr_n = clr_n + 1;
			end
			PH_IDLE: if (pop) tr_phase = PH_READ;
			PH_READ: tr_phase = PH_WRITE;
			default: tr_phase = PH_IDLE;
		endcase
	endtask

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// one clock: check what is due, then drive the next inputs 1 ns after the edge
	task automatic cycle_step(input logic lv, input logic [AW-1:0] laddr,
		input logic [ID_W-1:0] lid, input logic rv, input logic [AW-1:0] rpc,
		input logic rtaken);
		@(posedge clk);
		#1;
		advance_queue_model();
		check_value("queue_full_o", 32'(queue_full_o), 32'(q_count == QDEPTH));
		check_value("train_busy_o", 32'(train_busy_o),
			32'((tr_phase != PH_IDLE) || (q_count != 0)));
		check_value("pred_valid_o", 32'(pred_valid_o), 32'(exp_valid[1]));
		if (exp_valid[1]) begin
			check_value("pred_id_o", 32'(pred_id_o), 32'(exp_id[1]));
			check_value("pred_taken_o", 32'(pred_taken_o), 32'(exp_taken[1]));
		end
		exp_valid[1] = exp_valid[0];
		exp_taken[1] = exp_taken[0];
		exp_id[1] = exp_id[0];
		lookup_valid_i = lv;
		lookup_addr_i = laddr;
		lookup_id_i = lid;
		// prediction uses the model before any resolve of this same cycle
		exp_valid[0] = lv;
		exp_taken[0] = lv ? model_predict(laddr) : 1'b0;
		exp_id[0] = lid;
		resolve_valid_i = rv;
		resolve_pc_i = rpc;
		resolve_taken_i = rtaken;
		// a record pushed into a full queue is lost
		push_acc = rv && (q_count < QDEPTH);
		if (rv) begin
			if (push_acc) begin
				model_train(rpc, rtaken);
				accepted = accepted + 1;
			end else begin
				dropped = dropped + 1;
			end
		end
	endtask

	task automatic idle_step();
		cycle_step(1'b0, '0, '0, 1'b0, '0, 1'b0);
	endtask

	task automatic lookup_step(input logic [AW-1:0] addr, input logic [ID_W-1:0] id);
		cycle_step(1'b1, addr, id, 1'b0, '0, 1'b0);
	endtask

	task automatic resolve_step(input logic [AW-1:0] pc, input logic taken);
		cycle_step(1'b0, '0, '0, 1'b1, pc, taken);
	endtask

	// at least one step, so a push from the last cycle is seen as busy
	task automatic wait_idle();
		do begin
			idle_step();
		end while (train_busy_o);
	endtask

	// let the last two lookups come out and be checked
	task automatic drain();
		repeat (2) idle_step();
	endtask

	task automatic random_lookups(input int n, input logic pool_only);
		logic [31:0] r;
		logic [31:0] t;
		for (int k = 0; k < n; k++) begin
			r = next_rand();
			t = next_rand();
			if (pool_only || r[31])
				lookup_step(pc_pool[r[1:0]], t[ID_W-1:0]);
			else
				lookup_step(r, t[ID_W-1:0]);
		end
		drain();
	endtask

	// ======================================================================
	// watchdog
	// ======================================================================

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		stop_with_failure($sformatf("timeout after %0d cycles", WATCHDOG_CYCLES));
	end

	// ======================================================================
	// test sequence
	// ======================================================================

	initial begin
		int clear_cycles;
		int low_count;
		logic [31:0] r;
		logic [31:0] t;
		rst = 1'b1;
		lookup_valid_i = 1'b0;
		lookup_addr_i = '0;
		lookup_id_i = '0;
		resolve_valid_i = 1'b0;
		resolve_pc_i = '0;
		resolve_taken_i = 1'b0;
		rng_state = 32'h258161e7;
		model_hist = '0;
		q_count = 0;
		tr_phase = PH_CLEAR;
		clr_n = 0;
		push_acc = 1'b0;
		accepted = 0;
		dropped = 0;
		for (int i = 0; i < 2; i++) begin
			exp_valid[i] = 1'b0;
			exp_taken[i] = 1'b0;
			exp_id[i] = '0;
		end
		for (int row = 0; row < ROWS; row++)
			for (int i = 0; i < HL; i++)
				model_w[row][i] = 0;
		for (int p = 0; p < 4; p++)
			pc_pool[p] = next_rand();

		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		// trainer clears every row before it goes idle
		clear_cycles = 0;
		do begin
			idle_step();
			clear_cycles = clear_cycles + 1;
		end while (train_busy_o && clear_cycles < 300);
		if (train_busy_o)
			stop_with_failure("train_busy_o still high 300 cycles after reset");
		if (clear_cycles < ROWS)
			stop_with_failure("train_busy_o fell before all rows could be cleared");

		// zero row gives a zero sum, so taken
		r = next_rand();
		t = next_rand();
		lookup_step(r, t[ID_W-1:0]);
		drain();

		// back to back lookups, fixed latency and tags in order
		random_lookups(P2_LOOKUPS, 1'b0);

		// resolve bursts over a few branches
		for (int round = 0; round < P3_ROUNDS; round++) begin
			for (int k = 0; k < P3_BURST; k++) begin
				r = next_rand();
				resolve_step(pc_pool[r[1:0]], r[16]);
			end
			wait_idle();
			random_lookups(P3_LOOKUPS, 1'b0);
		end

		// one branch always taken, weights pile up at the top limit
		for (int g = 0; g < SAT_GROUPS; g++) begin
			for (int k = 0; k < GROUP_LEN; k++)
				resolve_step(32'h1234_5678, 1'b1);
			wait_idle();
		end
		lookup_step(32'h1234_5678, 8'h5a);
		drain();
		for (int i = 0; i < HL; i++)
			if (model_w[fold_index(32'h1234_5678)][i] != W_MAX)
				stop_with_failure("repeated taken branch did not reach the top weight");

		// alternating pair, history against outcome drives even weights down
		for (int g = 0; g < ALT_GROUPS; g++) begin
			for (int k = 0; k < GROUP_LEN; k++)
				resolve_step((k % 2 == 0) ? 32'h0000_0011 : 32'h0000_0022, (k % 2 == 0));
			wait_idle();
		end
		lookup_step(32'h0000_0011, 8'ha1);
		lookup_step(32'h0000_0022, 8'ha2);
		drain();
		low_count = 0;
		for (int i = 0; i < HL; i++)
			if (model_w[fold_index(32'h0000_0011)][i] == W_MIN)
				low_count = low_count + 1;
		if (low_count == 0)
			stop_with_failure("alternating branches did not reach the bottom weight");

		// overflow, records pushed while full are lost
		for (int k = 0; k < OVF_BURST; k++) begin
			r = next_rand();
			resolve_step(pc_pool[r[1:0]], r[9]);
		end
		wait_idle();
		if (dropped == 0)
			stop_with_failure("queue_full_o never rose during the overflow burst");
		random_lookups(OVF_LOOKUPS, 1'b1);

		$display("resolves accepted %0d dropped %0d", accepted, dropped);
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
src/bp_pkg.sv
src/resolve_queue.sv
src/weight_table.sv
src/perceptron_trainer.sv
src/perceptron_predictor.sv
src/branch_predictor_top.sv
sim/tb_branch_predictor.sv

// ==== Makefile ====
# Verilator build and run of the perceptron branch predictor testbench

VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
